// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // instruction word and address width
    localparam int WORD_W = 16;

    // words per cache line
    localparam int LINE_WORDS = 4;

    // two ways, fixed by the one-recent-bit replacement rule
    localparam int NUM_WAYS = 2;

    // word offset bits inside a line
    localparam int OFFSET_W = $clog2(LINE_WORDS);

    // tag keeps the full line address, index bits included
    localparam int TAG_W = WORD_W - OFFSET_W;

    // width of the access and hit counters
    localparam int COUNT_W = 16;

    typedef logic [WORD_W-1:0] word_t;

    // word k of a line holds the address with offset k
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

    // per-way bookkeeping for one set
    typedef struct packed {
        logic             valid;
        logic             recent;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// ==== cache_array_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface cache_array_if #(
    parameter type entry_t  = logic,
    parameter int  NUM_SETS = 2
) ();

    // set select, shared by read and write
    logic [$clog2(NUM_SETS)-1:0] index;
    logic                        we;

    // both ways are always written as a pair
    entry_t wdata_way0;
    entry_t wdata_way1;

    // combinational read of the selected set
    entry_t rdata_way0;
    entry_t rdata_way1;

    modport controller (
        output index, we, wdata_way0, wdata_way1,
        input  rdata_way0, rdata_way1
    );

    modport array (
        input  index, we, wdata_way0, wdata_way1,
        output rdata_way0, rdata_way1
    );

endinterface

`default_nettype wire

// ==== cache_set_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_set_array #(
    parameter type entry_t  = logic,
    parameter int  NUM_SETS = 2
) (
    input  wire logic    clk,
    input  wire logic    reset_n,
    cache_array_if.array bus
);

    // one entry per set in each way
    entry_t way0_mem [NUM_SETS];
    entry_t way1_mem [NUM_SETS];

    // read path is asynchronous so a hit completes in the request cycle
    assign bus.rdata_way0 = way0_mem[bus.index];
    assign bus.rdata_way1 = way1_mem[bus.index];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            // clearing the entries drops every valid bit
            for (int s = 0; s < NUM_SETS; s++) begin
                way0_mem[s] <= '0;
                way1_mem[s] <= '0;
            end
        end else if (bus.we) begin
            way0_mem[bus.index] <= bus.wdata_way0;
            way1_mem[bus.index] <= bus.wdata_way1;
        end
    end

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
#(
    parameter int NUM_SETS = 2
) (
    input  wire logic         clk,
    input  wire logic         reset_n,

    // processor side
    input  wire logic         cpu_valid,
    input  wire word_t        cpu_addr,
    output logic              cpu_ready,
    output word_t             cpu_data,

    // memory side
    output logic              mem_read,
    output word_t             mem_addr,
    input  wire logic         mem_ready,
    input  wire line_t        mem_line,

    // statistics
    output logic [COUNT_W-1:0] access_count,
    output logic [COUNT_W-1:0] hit_count,

    cache_array_if.controller tag_bus,
    cache_array_if.controller data_bus
);

    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int WAY_W   = $clog2(NUM_WAYS);

    typedef enum logic {
        ST_CHECK,
        ST_FILL
    } state_t;

    state_t state_q;
    state_t state_d;

    logic [WAY_W-1:0] victim_q;
    logic [WAY_W-1:0] victim_d;

    logic [OFFSET_W-1:0] addr_offset;
    logic [INDEX_W-1:0]  addr_index;
    logic [TAG_W-1:0]    addr_tag;

    tag_entry_t tag_rd0;
    tag_entry_t tag_rd1;
    tag_entry_t tag_wr0;
    tag_entry_t tag_wr1;

    logic  way0_hit;
    logic  way1_hit;
    logic  cache_hit;
    line_t hit_line;

    // address split
    assign addr_offset = cpu_addr[OFFSET_W-1:0];
    assign addr_index  = cpu_addr[OFFSET_W +: INDEX_W];
    assign addr_tag    = cpu_addr[WORD_W-1:OFFSET_W];

    // line-aligned fill address
    assign mem_addr = {addr_tag, {OFFSET_W{1'b0}}};

    assign tag_bus.index  = addr_index;
    assign data_bus.index = addr_index;

    assign tag_rd0 = tag_bus.rdata_way0;
    assign tag_rd1 = tag_bus.rdata_way1;

    assign way0_hit  = tag_rd0.valid && (tag_rd0.tag == addr_tag);
    assign way1_hit  = tag_rd1.valid && (tag_rd1.tag == addr_tag);
    assign cache_hit = way0_hit || way1_hit;
    assign hit_line  = way0_hit ? data_bus.rdata_way0 : data_bus.rdata_way1;

    // way 0 is evicted unless it was the last one used
    assign victim_d = tag_rd0.recent ? WAY_W'(1) : WAY_W'(0);

    assign tag_bus.wdata_way0 = tag_wr0;
    assign tag_bus.wdata_way1 = tag_wr1;

    always_comb begin
        state_d   = state_q;
        cpu_ready = 1'b0;
        cpu_data  = hit_line[addr_offset];
        mem_read  = 1'b0;

        // default write-back leaves both ways unchanged
        tag_bus.we          = 1'b0;
        tag_wr0             = tag_rd0;
        tag_wr1             = tag_rd1;
        data_bus.we         = 1'b0;
        data_bus.wdata_way0 = data_bus.rdata_way0;
        data_bus.wdata_way1 = data_bus.rdata_way1;

        case (state_q)
            ST_CHECK: begin
                if (cpu_valid) begin
                    if (cache_hit) begin
                        cpu_ready      = 1'b1;
                        tag_bus.we     = 1'b1;
                        tag_wr0.recent = way0_hit;
                        tag_wr1.recent = !way0_hit;
                    end else begin
                        mem_read = 1'b1;
                        state_d  = ST_FILL;
                    end
                end
            end

            ST_FILL: begin
                // hold the request until memory delivers the line
                mem_read = 1'b1;
                if (mem_ready) begin
                    cpu_ready   = 1'b1;
                    cpu_data    = mem_line[addr_offset];
                    tag_bus.we  = 1'b1;
                    data_bus.we = 1'b1;
                    if (victim_q == WAY_W'(0)) begin
                        data_bus.wdata_way0 = mem_line;
                        tag_wr0.valid       = 1'b1;
                        tag_wr0.recent      = 1'b1;
                        tag_wr0.tag         = addr_tag;
                        tag_wr1.recent      = 1'b0;
                    end else begin
                        data_bus.wdata_way1 = mem_line;
                        tag_wr1.valid       = 1'b1;
                        tag_wr1.recent      = 1'b1;
                        tag_wr1.tag         = addr_tag;
                        tag_wr0.recent      = 1'b0;
                    end
                    state_d = ST_CHECK;
                end
            end

            default: begin
                state_d = ST_CHECK;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q  <= ST_CHECK;
            victim_q <= '0;
        end else begin
            state_q <= state_d;
            // victim is fixed when the miss is seen
            if (state_q == ST_CHECK && state_d == ST_FILL) begin
                victim_q <= victim_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            access_count <= '0;
            hit_count    <= '0;
        end else if (cpu_ready) begin
            access_count <= access_count + 1'b1;
            // a completion straight from check is a hit
            if (state_q == ST_CHECK) begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int NUM_SETS = 2
) (
    input  wire logic          clk,
    input  wire logic          reset_n,

    // fetch port
    input  wire logic          cpu_valid,
    input  wire word_t         cpu_addr,
    output logic               cpu_ready,
    output word_t              cpu_data,

    // line refill port
    output logic               mem_read,
    output word_t              mem_addr,
    input  wire logic          mem_ready,
    input  wire line_t         mem_line,

    output logic [COUNT_W-1:0] access_count,
    output logic [COUNT_W-1:0] hit_count
);

    cache_array_if #(
        .entry_t  (tag_entry_t),
        .NUM_SETS (NUM_SETS)
    ) tag_bus ();

    cache_array_if #(
        .entry_t  (line_t),
        .NUM_SETS (NUM_SETS)
    ) data_bus ();

    icache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_valid    (cpu_valid),
        .cpu_addr     (cpu_addr),
        .cpu_ready    (cpu_ready),
        .cpu_data     (cpu_data),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .mem_ready    (mem_ready),
        .mem_line     (mem_line),
        .access_count (access_count),
        .hit_count    (hit_count),
        .tag_bus      (tag_bus.controller),
        .data_bus     (data_bus.controller)
    );

    // valid, recent and tag per way
    cache_set_array #(
        .entry_t  (tag_entry_t),
        .NUM_SETS (NUM_SETS)
    ) u_tag_array (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (tag_bus.array)
    );

    // four-word lines per way
    cache_set_array #(
        .entry_t  (line_t),
        .NUM_SETS (NUM_SETS)
    ) u_data_array (
        .clk     (clk),
        .reset_n (reset_n),
        .bus     (data_bus.array)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // power-on reset, released on a falling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_icache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_icache
    import icache_pkg::*;
();

    localparam int    NUM_SETS         = 2;
    localparam int    NUM_ENTRIES      = 20;
    localparam int    RESET_CYCLES     = 8;
    localparam int    CYCLES_PER_ENTRY = 20;
    localparam word_t DATA_KEY         = 16'hc3a5;

    wire clk;
    wire por_n;
    wire reset_n;

    logic               soft_reset_n;
    logic               cpu_valid;
    word_t              cpu_addr;
    logic               cpu_ready;
    word_t              cpu_data;
    logic               mem_read;
    word_t              mem_addr;
    logic               mem_ready;
    line_t              mem_line;
    logic [COUNT_W-1:0] access_count;
    logic [COUNT_W-1:0] hit_count;

    // fetch table
    word_t fetch_addr  [NUM_ENTRIES];
    logic  fetch_hit   [NUM_ENTRIES];
    logic  fetch_reset [NUM_ENTRIES];
    int    n_loaded;

    integer seed = 32'h647d_43aa;
    int     exp_access;
    int     exp_hits;

    assign reset_n = por_n & soft_reset_n;

    tb_clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk     (clk),
        .reset_n (por_n)
    );

    icache_top #(
        .NUM_SETS (NUM_SETS)
    ) u_icache_top (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_valid    (cpu_valid),
        .cpu_addr     (cpu_addr),
        .cpu_ready    (cpu_ready),
        .cpu_data     (cpu_data),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .mem_ready    (mem_ready),
        .mem_line     (mem_line),
        .access_count (access_count),
        .hit_count    (hit_count)
    );

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: %s", msg);
        abort_run();
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // word at address a holds a xor key
    function automatic line_t expected_line(input word_t base);
        line_t line;
        for (int k = 0; k < LINE_WORDS; k++) begin
            line[k] = (base | word_t'(k)) ^ DATA_KEY;
        end
        return line;
    endfunction

    task automatic add_fetch(input word_t addr, input logic hit, input logic rst);
        fetch_addr[n_loaded]  = addr;
        fetch_hit[n_loaded]   = hit;
        fetch_reset[n_loaded] = rst;
        n_loaded++;
    endtask

    // set is addr[2] with two sets
    task automatic load_table();
        add_fetch(16'h0010, 1'b0, 1'b0); // cold miss, line A into way 0
        add_fetch(16'h0013, 1'b1, 1'b0); // other word of A
        add_fetch(16'h0028, 1'b0, 1'b0); // line B, same set, way 1
        add_fetch(16'h0011, 1'b1, 1'b0);
        add_fetch(16'h002a, 1'b1, 1'b0);
        add_fetch(16'h0012, 1'b1, 1'b0);
        add_fetch(16'h0029, 1'b1, 1'b0); // B last used
        add_fetch(16'h0040, 1'b0, 1'b0); // line C evicts A in way 0
        add_fetch(16'h002b, 1'b1, 1'b0); // B kept
        add_fetch(16'h0013, 1'b0, 1'b0); // A again, evicts C
        add_fetch(16'h0043, 1'b0, 1'b0); // C again, evicts B
        add_fetch(16'h0006, 1'b0, 1'b0); // cold line in set 1
        add_fetch(16'h0005, 1'b1, 1'b0);
        add_fetch(16'h0012, 1'b1, 1'b0);
        add_fetch(16'h0012, 1'b0, 1'b1); // after reset the cache is empty
        add_fetch(16'h0011, 1'b1, 1'b0);
        add_fetch(16'h0044, 1'b0, 1'b0);
        add_fetch(16'h0047, 1'b1, 1'b0);
        add_fetch(16'hfff9, 1'b0, 1'b0); // high tag bits
        add_fetch(16'hfffa, 1'b1, 1'b0);
    endtask

    task automatic apply_reset();
        cpu_valid    = 1'b0;
        soft_reset_n = 1'b0;
        repeat (2) @(negedge clk);
        soft_reset_n = 1'b1;
        exp_access   = 0;
        exp_hits     = 0;
        check_equal("access_count", access_count, 0);
        check_equal("hit_count", hit_count, 0);
    endtask

    // a miss keeps mem_read high with the line address until the line arrives
    task automatic check_fill_request(input word_t addr, input word_t line_base);
        if (!mem_read) begin
            report_failure($sformatf("fetch of 0x%04h expected to miss did not hold mem_read",
                                     addr));
        end else if (mem_addr !== line_base) begin
            report_failure($sformatf("mem_addr 0x%04h is not the line address 0x%04h",
                                     mem_addr, line_base));
        end
    endtask

    // called on a falling edge, returns on the falling edge after completion
    task automatic run_fetch(input int idx);
        word_t addr;
        word_t line_base;
        logic  exp_hit;
        addr      = fetch_addr[idx];
        exp_hit   = fetch_hit[idx];
        line_base = addr & ~word_t'(LINE_WORDS - 1);

        cpu_valid = 1'b1;
        cpu_addr  = addr;
        #1;
        if (exp_hit && mem_read) begin
            report_failure($sformatf("mem_read raised on a fetch of 0x%04h expected to hit",
                                     addr));
        end else if (exp_hit && !cpu_ready) begin
            report_failure($sformatf("fetch of 0x%04h expected to hit did not complete at once",
                                     addr));
        end

        while (!cpu_ready) begin
            check_fill_request(addr, line_base);
            @(negedge clk);
            #1;
        end
        if (!exp_hit) begin
            check_fill_request(addr, line_base);
        end
        check_equal("cpu_data", cpu_data, addr ^ DATA_KEY);

        @(negedge clk);
        exp_access++;
        if (exp_hit) begin
            exp_hits++;
        end
        check_equal("access_count", access_count, exp_access);
        check_equal("hit_count", hit_count, exp_hits);
    endtask

    // memory answers after 1 to 4 cycles
    initial begin
        int unsigned delay;
        word_t       req_base;
        mem_ready = 1'b0;
        mem_line  = '0;
        @(negedge clk);
        forever begin
            #1;
            if (mem_read) begin
                req_base = mem_addr;
                delay    = 1 + ({$random(seed)} % 4);
                repeat (delay) @(negedge clk);
                mem_line  = expected_line(req_base);
                mem_ready = 1'b1;
                @(negedge clk);
                mem_ready = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + NUM_ENTRIES * CYCLES_PER_ENTRY) @(posedge clk);
        report_failure("watchdog expired before the fetch table finished");
    end

    initial begin
        cpu_valid    = 1'b0;
        cpu_addr     = '0;
        soft_reset_n = 1'b1;
        exp_access   = 0;
        exp_hits     = 0;
        n_loaded     = 0;
        load_table();

        wait (por_n === 1'b1);
        @(negedge clk);
        check_equal("access_count", access_count, 0);
        check_equal("hit_count", hit_count, 0);

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (fetch_reset[i]) begin
                apply_reset();
            end
            run_fetch(i);
        end
        cpu_valid = 1'b0;
        @(negedge clk);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
icache_pkg.sv
cache_array_if.sv
cache_set_array.sv
icache_ctrl.sv
icache_top.sv
tb_clock_gen.sv
tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - icache_pkg.sv
  - cache_array_if.sv
  - cache_set_array.sv
  - icache_ctrl.sv
  - icache_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_icache.sv
